//--- vlog.f
verilog/reg_bus_pkg.sv
verilog/harness_cfg_pkg.sv
verilog/ext_periph_addr_decode.sv
verilog/ext_periph_reg_demux.sv
verilog/pg_switch_ack_model.sv
verilog/ext_harness.sv
testbench/tb_periph_model.sv
testbench/tb_ext_harness.sv

//--- testbench/tb_ext_harness.sv
// ****************************************
// Testbench of the external harness block
// Checks register routing, unmapped errors
// and power-switch acks
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module tb_ext_harness;

  import reg_bus_pkg::*;
  import harness_cfg_pkg::*;

  localparam int CLK_PERIOD       = 20;
  localparam int RESET_CYCLES     = 3;
  localparam int RAND_SEED        = 62827;
  localparam int SW_IDLE_CYCLES   = 40;
  localparam int SW_RANDOM_CYCLES = 200;
  localparam int ACK_DELAY_EDGES  = SWITCH_ACK_LATENCY + 1;
  localparam int SW_DRAIN_CYCLES  = ACK_DELAY_EDGES + 4;
  localparam int N_RW             = 8;   // Write/read pairs per peripheral
  localparam int N_MISS           = 12;
  localparam int XFER_TIMEOUT     = 16;
  localparam int N_XFERS          = 2 * EXT_NPERIPH * N_RW + N_MISS;
  localparam int TEST_CYCLES      = RESET_CYCLES + SW_IDLE_CYCLES + SW_RANDOM_CYCLES +
                                    SW_DRAIN_CYCLES + N_XFERS * (XFER_TIMEOUT + 2);
  localparam int WATCHDOG_NS      = (TEST_CYCLES + 100) * CLK_PERIOD;

  localparam reg_rsp_t MISS_RSP = '{rdata: '0, error: 1'b1, ready: 1'b1};

  logic                            clk;
  logic                            rst_n;
  reg_req_t                        reg_req;
  reg_rsp_t                        reg_rsp;
  reg_req_t [EXT_NPERIPH-1:0]      periph_req;
  reg_rsp_t [EXT_NPERIPH-1:0]      periph_rsp;
  pg_switch_t                      pg_switch_n;
  pg_switch_t                      pg_switch_ack_n;

  integer     seed = RAND_SEED;
  int         error_count = 0;
  int         xfer_count = 0;
  int         stall_cycles = 0;
  int         in_toggles = 0;
  int         ack_toggles = 0;
  pg_switch_t prev_ack = '1;
  pg_switch_t sw_hist [$];  // Newest sample first
  reg_data_t  ref_mem [EXT_NPERIPH][16];

  ext_harness UUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .reg_req_i         (reg_req),
    .reg_rsp_o         (reg_rsp),
    .periph_req_o      (periph_req),
    .periph_rsp_i      (periph_rsp),
    .pg_switch_n_i     (pg_switch_n),
    .pg_switch_ack_n_o (pg_switch_ack_n)
  );

  for (genvar p = 0; p < EXT_NPERIPH; p++) begin : g_periph
    tb_periph_model #(
      .SEED (RAND_SEED + p + 1)
    ) periph_model_i (
      .clk_i   (clk),
      .rst_n_i (rst_n),
      .req_i   (periph_req[p]),
      .rsp_o   (periph_rsp[p])
    );
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Windows are contiguous from the base, one per peripheral
  function automatic logic ref_hit(input reg_addr_t addr);
    return (addr >= EXT_PERIPH_BASE_ADDR) &&
           (addr < EXT_PERIPH_BASE_ADDR + EXT_NPERIPH * EXT_PERIPH_SIZE);
  endfunction

  function automatic periph_idx_t ref_idx(input reg_addr_t addr);
    reg_addr_t offset;
    offset = addr - EXT_PERIPH_BASE_ADDR;
    return periph_idx_t'(offset / EXT_PERIPH_SIZE);
  endfunction

  function automatic reg_data_t merge_strobes(input reg_data_t old_word, input reg_data_t wdata,
                                              input reg_strb_t wstrb);
    reg_data_t merged;
    merged = old_word;
    for (int b = 0; b < REG_STRB_WIDTH; b++) begin
      if (wstrb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
    end
    return merged;
  endfunction

  // Sample from ACK_DELAY_EDGES falling edges ago, all high before that
  function automatic pg_switch_t ref_switch_ack(input pg_switch_t hist [$]);
    if (hist.size() < ACK_DELAY_EDGES) return '1;
    return hist[ACK_DELAY_EDGES-1];
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    error_count++;
    $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic bus_transfer(input reg_addr_t addr, input logic write, input reg_data_t wdata,
                              input reg_strb_t wstrb, output reg_rsp_t rsp, output int cycles);
    reg_req_t req;
    logic     done;
    req   = '{addr: addr, write: write, wdata: wdata, wstrb: wstrb, valid: 1'b1};
    rsp   = '0;
    done  = 1'b0;
    cycles = 0;
    @(negedge clk);
    reg_req <= req;
    while (!done && cycles < XFER_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (reg_rsp.ready === 1'b1) begin
        rsp  = reg_rsp;
        done = 1'b1;
      end
    end
    if (!done) begin
      error_count++;
      $display("Transfer to address %h got no ready within %0d cycles", addr, XFER_TIMEOUT);
    end
    xfer_count++;
    @(negedge clk);
    reg_req <= '0;
  endtask

  task automatic run_switch_test();
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    pg_switch_t  flip;
    repeat (SW_IDLE_CYCLES) @(negedge clk);  // Requests held inactive
    for (int n = 0; n < SW_RANDOM_CYCLES; n++) begin
      @(negedge clk);
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      flip  = pg_switch_t'(rnd_a & rnd_b);  // Each bit flips with p = 1/4
      pg_switch_n <= pg_switch_n ^ flip;
      in_toggles += $countones(flip);
    end
    repeat (SW_DRAIN_CYCLES) @(negedge clk);
  endtask

  task automatic run_register_test();
    logic [31:0] rnd;
    reg_addr_t   addr;
    reg_data_t   wdata;
    reg_strb_t   wstrb;
    reg_rsp_t    rsp;
    int          cycles;
    reg_data_t   exp_rdata;
    for (int p = 0; p < EXT_NPERIPH; p++) begin
      for (int k = 0; k < N_RW; k++) begin
        rnd   = $random(seed);
        addr  = EXT_PERIPH_BASE_ADDR + p * EXT_PERIPH_SIZE + (rnd & 32'h0000_0ffc);
        wstrb = rnd[15:12];
        wdata = $random(seed);
        bus_transfer(addr, 1'b1, wdata, wstrb, rsp, cycles);
        if (rsp.error !== 1'b0) report_mismatch("reg_rsp_o.error", 1'b0, rsp.error);
        ref_mem[p][addr[5:2]] = merge_strobes(ref_mem[p][addr[5:2]], wdata, wstrb);
        // Read back with junk on the write fields
        bus_transfer(addr, 1'b0, $random(seed), '1, rsp, cycles);
        exp_rdata = ref_mem[p][addr[5:2]];
        if (rsp.rdata !== exp_rdata) report_mismatch("reg_rsp_o.rdata", exp_rdata, rsp.rdata);
        if (rsp.error !== 1'b0) report_mismatch("reg_rsp_o.error", 1'b0, rsp.error);
      end
    end
  endtask

  task automatic run_unmapped_test();
    logic [31:0] rnd;
    reg_addr_t   addr;
    reg_rsp_t    rsp;
    int          cycles;
    for (int k = 0; k < N_MISS; k++) begin
      rnd = $random(seed);
      if (k == 0) begin
        addr = EXT_PERIPH_BASE_ADDR - 4;  // Just below the first window
      end else if (k == 1) begin
        addr = EXT_PERIPH_BASE_ADDR + EXT_NPERIPH * EXT_PERIPH_SIZE;
      end else begin
        addr = {rnd[31:2], 2'b00};
        if (ref_hit(addr)) addr = addr ^ 32'h8000_0000;
      end
      bus_transfer(addr, rnd[0], $random(seed), rnd[7:4], rsp, cycles);
      if (cycles != 1) begin
        error_count++;
        $display("Unmapped access to %h took %0d cycles instead of one", addr, cycles);
      end
      if (rsp.error !== 1'b1) report_mismatch("reg_rsp_o.error", 1'b1, rsp.error);
      if (rsp.rdata !== '0) report_mismatch("reg_rsp_o.rdata", 0, rsp.rdata);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      sw_hist.delete();
    end else begin
      sw_hist.push_front(pg_switch_n);
      if (sw_hist.size() > ACK_DELAY_EDGES) void'(sw_hist.pop_back());
    end
  end

  always @(posedge clk) begin : switch_check
    pg_switch_t exp_ack;
    if (rst_n === 1'b1) begin
      exp_ack = ref_switch_ack(sw_hist);
      if (pg_switch_ack_n !== exp_ack) begin
        report_mismatch("pg_switch_ack_n_o", exp_ack, pg_switch_ack_n);
      end
      ack_toggles += $countones(pg_switch_ack_n ^ prev_ack);
      prev_ack = pg_switch_ack_n;
    end
  end

  // Request routing and response path, every cycle of a transfer
  always @(posedge clk) begin : bus_check
    logic        exp_hit;
    periph_idx_t exp_idx;
    logic        exp_valid;
    if (rst_n === 1'b1 && reg_req.valid === 1'b1) begin
      exp_hit = ref_hit(reg_req.addr);
      exp_idx = ref_idx(reg_req.addr);
      for (int i = 0; i < EXT_NPERIPH; i++) begin
        exp_valid = exp_hit && (exp_idx == i);
        if (periph_req[i].valid !== exp_valid) begin
          report_mismatch($sformatf("periph_req_o[%0d].valid", i), exp_valid,
                          periph_req[i].valid);
        end
        if (exp_valid && periph_req[i] !== reg_req) begin
          report_mismatch($sformatf("periph_req_o[%0d]", i), reg_req, periph_req[i]);
        end
      end
      if (exp_hit) begin
        if (reg_rsp !== periph_rsp[exp_idx]) begin
          report_mismatch("reg_rsp_o", periph_rsp[exp_idx], reg_rsp);
        end
        if (reg_rsp.ready !== 1'b1) stall_cycles++;
      end else if (reg_rsp !== MISS_RSP) begin
        report_mismatch("reg_rsp_o", MISS_RSP, reg_rsp);
      end
    end
  end

  initial begin : stimulus
    rst_n       = 1'b0;
    reg_req     = '0;
    pg_switch_n = '1;
    for (int p = 0; p < EXT_NPERIPH; p++) begin
      for (int w = 0; w < 16; w++) begin
        ref_mem[p][w] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;

    run_switch_test();
    run_register_test();
    run_unmapped_test();
    repeat (4) @(negedge clk);

    if (ack_toggles != in_toggles) begin
      error_count++;
      $display("Switch acks changed %0d times for %0d request changes", ack_toggles,
               in_toggles);
    end
    if (stall_cycles == 0) begin
      error_count++;
      $display("No wait for ready was seen on any register transfer");
    end
    $display("Finished with %0d errors over %0d transfers", error_count, xfer_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, error_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_periph_model.sv
// ****************************************
// Behavioral register peripheral for the
// testbench, 16 words and a random wait
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module tb_periph_model #(
  parameter int SEED = 62827
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  reg_bus_pkg::reg_req_t req_i,
  output reg_bus_pkg::reg_rsp_t rsp_o
);

  import reg_bus_pkg::*;

  reg_data_t   mem [16];
  logic        busy;
  logic [1:0]  wait_cnt;
  logic [3:0]  word_idx;
  logic [31:0] rnd;
  integer      seed;

  initial seed = SEED;

  assign word_idx = req_i.addr[5:2];  // Word select

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy     <= 1'b0;
      wait_cnt <= '0;
      rsp_o    <= '0;
      for (int w = 0; w < 16; w++) begin
        mem[w] <= '0;
      end
    end else if (rsp_o.ready) begin
      // Transfer completes on this edge
      rsp_o.ready <= 1'b0;
      busy        <= 1'b0;
    end else if (busy) begin
      if (wait_cnt == 0) begin
        rsp_o.ready <= 1'b1;
        rsp_o.error <= 1'b0;
        if (req_i.write) begin
          for (int b = 0; b < REG_STRB_WIDTH; b++) begin
            if (req_i.wstrb[b]) begin
              mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
          end
        end else begin
          rsp_o.rdata <= mem[word_idx];
        end
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (req_i.valid) begin
      rnd      = $random(seed);
      busy     <= 1'b1;
      wait_cnt <= rnd[1:0];  // 0 to 3 extra cycles
    end
  end

endmodule

`default_nettype wire

//--- verilog/ext_harness.sv
// ****************************************
// External side of the MCU test harness
// Register peripheral routing and switch acks
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module ext_harness (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,

  // Register bus from the MCU
  input  reg_bus_pkg::reg_req_t                               reg_req_i,
  output reg_bus_pkg::reg_rsp_t                               reg_rsp_o,

  // External register peripherals
  output reg_bus_pkg::reg_req_t [harness_cfg_pkg::EXT_NPERIPH-1:0] periph_req_o,
  input  reg_bus_pkg::reg_rsp_t [harness_cfg_pkg::EXT_NPERIPH-1:0] periph_rsp_i,

  // Power switches, active low
  input  harness_cfg_pkg::pg_switch_t                         pg_switch_n_i,
  output harness_cfg_pkg::pg_switch_t                         pg_switch_ack_n_o
);

  import reg_bus_pkg::*;
  import harness_cfg_pkg::*;

  periph_idx_t periph_sel_idx;
  logic        periph_sel_hit;

  ext_periph_addr_decode ext_periph_addr_decode_i (
    .addr_i (reg_req_i.addr),
    .idx_o  (periph_sel_idx),
    .hit_o  (periph_sel_hit)
  );

  ext_periph_reg_demux ext_periph_reg_demux_i (
    .req_i        (reg_req_i),
    .rsp_o        (reg_rsp_o),
    .idx_i        (periph_sel_idx),
    .hit_i        (periph_sel_hit),
    .periph_req_o (periph_req_o),
    .periph_rsp_i (periph_rsp_i)
  );

  // Independent of the register path
  pg_switch_ack_model pg_switch_ack_model_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (pg_switch_n_i),
    .ack_n_o    (pg_switch_ack_n_o)
  );

endmodule

`default_nettype wire

//--- verilog/pg_switch_ack_model.sv
// ****************************************
// Power-switch cell model, returns each
// request as ack after a falling-edge delay
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module pg_switch_ack_model (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  harness_cfg_pkg::pg_switch_t switch_n_i,
  output harness_cfg_pkg::pg_switch_t ack_n_o
);

  import harness_cfg_pkg::*;

  // Stage 0 is the capture, the last stage drives the ack
  pg_switch_t [SWITCH_ACK_LATENCY:0] stage_q;

  // Switched off by default, so every line starts high
  always_ff @(negedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= '1;
    end else begin
      stage_q <= {stage_q[SWITCH_ACK_LATENCY-1:0], switch_n_i};
    end
  end

  assign ack_n_o = stage_q[SWITCH_ACK_LATENCY];

endmodule

`default_nettype wire

//--- verilog/ext_periph_reg_demux.sv
// ****************************************
// Register request demux to the external
// peripherals, errors on unmapped addresses
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module ext_periph_reg_demux (
  input  reg_bus_pkg::reg_req_t                               req_i,
  output reg_bus_pkg::reg_rsp_t                               rsp_o,
  input  harness_cfg_pkg::periph_idx_t                        idx_i,
  input  logic                                                hit_i,
  output reg_bus_pkg::reg_req_t [harness_cfg_pkg::EXT_NPERIPH-1:0] periph_req_o,
  input  reg_bus_pkg::reg_rsp_t [harness_cfg_pkg::EXT_NPERIPH-1:0] periph_rsp_i
);

  import reg_bus_pkg::*;
  import harness_cfg_pkg::*;

  reg_rsp_t sel_rsp;

  // Payload fans out to all ports, valid only to the selected one
  always_comb begin
    for (int unsigned i = 0; i < EXT_NPERIPH; i++) begin
      periph_req_o[i]       = req_i;
      periph_req_o[i].valid = req_i.valid && hit_i && (idx_i == periph_idx_t'(i));
    end
  end

  assign sel_rsp = periph_rsp_i[idx_i];

  always_comb begin
    if (hit_i) begin
      rsp_o = sel_rsp;  // Straight through
    end else begin
      // Unmapped, answered at once
      rsp_o.rdata = '0;
      rsp_o.error = 1'b1;
      rsp_o.ready = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ext_periph_addr_decode.sv
// ****************************************
// Address decoder for the external
// peripherals, gives index and hit flag
// ****************************************

`timescale 1ns/1ns
`default_nettype none

module ext_periph_addr_decode (
  input  reg_bus_pkg::reg_addr_t      addr_i,
  output harness_cfg_pkg::periph_idx_t idx_o,
  output logic                        hit_o
);

  import reg_bus_pkg::*;
  import harness_cfg_pkg::*;

  logic [EXT_NPERIPH-1:0] rule_match;

  // Range check of every window in parallel
  always_comb begin
    for (int unsigned i = 0; i < EXT_NPERIPH; i++) begin
      rule_match[i] = (addr_i >= EXT_PERIPH_RULES[i].start_addr) &&
                      (addr_i <  EXT_PERIPH_RULES[i].end_addr);
    end
  end

  // Lowest matching rule wins, index zero on a miss
  always_comb begin
    idx_o = '0;
    hit_o = |rule_match;
    for (int i = EXT_NPERIPH - 1; i >= 0; i--) begin
      if (rule_match[i]) begin
        idx_o = EXT_PERIPH_RULES[i].idx;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/harness_cfg_pkg.sv
// ****************************************
// Address map and power-switch domains
// of the external harness side
// ****************************************

`default_nettype none

package harness_cfg_pkg;

  localparam int unsigned EXT_NPERIPH = 4;

  typedef logic [$clog2(EXT_NPERIPH)-1:0] periph_idx_t;

  localparam periph_idx_t MEMCOPY_CTRL_IDX = 2'd0;
  localparam periph_idx_t AMS_IDX          = 2'd1;
  localparam periph_idx_t IFFIFO_IDX       = 2'd2;
  localparam periph_idx_t SL_REG_IDX       = 2'd3;

  localparam reg_bus_pkg::reg_addr_t EXT_PERIPH_BASE_ADDR = 32'h2008_0000;
  localparam reg_bus_pkg::reg_addr_t EXT_PERIPH_SIZE      = 32'h0000_1000;

  // One address window per peripheral, end_addr exclusive
  typedef struct packed {
    periph_idx_t             idx;
    reg_bus_pkg::reg_addr_t  start_addr;
    reg_bus_pkg::reg_addr_t  end_addr;
  } addr_rule_t;

  localparam addr_rule_t EXT_PERIPH_RULES [EXT_NPERIPH] = '{
    '{idx:        MEMCOPY_CTRL_IDX,
      start_addr: EXT_PERIPH_BASE_ADDR + MEMCOPY_CTRL_IDX * EXT_PERIPH_SIZE,
      end_addr:   EXT_PERIPH_BASE_ADDR + (MEMCOPY_CTRL_IDX + 1) * EXT_PERIPH_SIZE},
    '{idx:        AMS_IDX,
      start_addr: EXT_PERIPH_BASE_ADDR + AMS_IDX * EXT_PERIPH_SIZE,
      end_addr:   EXT_PERIPH_BASE_ADDR + (AMS_IDX + 1) * EXT_PERIPH_SIZE},
    '{idx:        IFFIFO_IDX,
      start_addr: EXT_PERIPH_BASE_ADDR + IFFIFO_IDX * EXT_PERIPH_SIZE,
      end_addr:   EXT_PERIPH_BASE_ADDR + (IFFIFO_IDX + 1) * EXT_PERIPH_SIZE},
    '{idx:        SL_REG_IDX,
      start_addr: EXT_PERIPH_BASE_ADDR + SL_REG_IDX * EXT_PERIPH_SIZE,
      end_addr:   EXT_PERIPH_BASE_ADDR + (SL_REG_IDX + 1) * EXT_PERIPH_SIZE}
  };

  localparam int unsigned NUM_BANKS   = 2;
  localparam int unsigned EXT_DOMAINS = 1;

  // Stages behind the first capture
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // Switch request or acknowledge lines, all active low
  typedef struct packed {
    logic                   cpu;
    logic                   periph;
    logic [NUM_BANKS-1:0]   mem_banks;
    logic [EXT_DOMAINS-1:0] ext;
  } pg_switch_t;

endpackage

`default_nettype wire

//--- verilog/reg_bus_pkg.sv
// ****************************************
// Register bus types for the harness fabric
// Import into any block on the register bus
// ****************************************

`default_nettype none

package reg_bus_pkg;

  localparam int unsigned REG_ADDR_WIDTH = 32;
  localparam int unsigned REG_DATA_WIDTH = 32;
  localparam int unsigned REG_STRB_WIDTH = REG_DATA_WIDTH / 8;

  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;  // Byte address
  typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [REG_STRB_WIDTH-1:0] reg_strb_t;  // One bit per byte lane

  // Master to peripheral, held until ready
  typedef struct packed {
    reg_addr_t addr;
    logic      write;
    reg_data_t wdata;
    reg_strb_t wstrb;
    logic      valid;
  } reg_req_t;

  // Peripheral to master
  typedef struct packed {
    reg_data_t rdata;
    logic      error;
    logic      ready;  // Completes the transfer on a rising edge
  } reg_rsp_t;

endpackage

`default_nettype wire
